//--- files.f
design/img_pkg.sv
design/filt_pkg.sv
design/pixel_column_if.sv
design/window_if.sv
design/line_buffer.sv
design/window_sum.sv
design/threshold_out.sv
design/box_thresh_top.sv
verif/box_thresh_properties.sv
verif/result_checker.sv
verif/tb_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= SIMULATION PASSED
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verif/tb_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_top;

    localparam int          CLK_HALF      = 20;
    localparam int          RESET_CYCLES  = 4;
    localparam int          NUM_TESTS     = 6;
    localparam int          OUT_PER_FRAME = 48;
    localparam int          WAIT_LIMIT    = 400;
    localparam int          DRAIN_CYCLES  = 8;
    localparam logic [15:0] LFSR_SEED     = 16'd37369;
    localparam int          KIND_CONST    = 0;
    localparam int          KIND_RAMP     = 1;
    localparam int          KIND_CHECKER  = 2;
    localparam int          KIND_RANDOM   = 3;

    // two rows and a few pixels, short of the row where the window forms.
    localparam int          ABORT_PIXELS  = 2 * img_pkg::IMG_COLS + 5;

    logic               clk = 1'b0;
    logic               rst;
    logic               i_pix_valid;
    logic               i_sof;
    img_pkg::pixel_t    i_pixel;
    logic               o_valid;
    filt_pkg::win_sum_t o_sum;
    img_pkg::pixel_t    o_center;
    img_pkg::coord_t    o_row;
    img_pkg::coord_t    o_col;
    logic               o_bin;

    logic        test_end;
    int          test_idx;
    int          exp_ones;
    int          frame_outputs;
    int          error_count;
    int          total_outputs;
    int          timeouts;
    int          tests_run;
    logic [15:0] lfsr;

    // test table, one frame per row. a negative count is not fixed by the rule.
    // t_abort pixels of an abandoned frame go out before the full frame.
    string           t_name  [NUM_TESTS];
    int              t_kind  [NUM_TESTS];
    img_pkg::pixel_t t_const [NUM_TESTS];
    logic            t_gaps  [NUM_TESTS];
    int              t_ones  [NUM_TESTS];
    int              t_abort [NUM_TESTS];

    always #CLK_HALF clk = ~clk;

    box_thresh_top UUT (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .i_sof       (i_sof),
        .i_pixel     (i_pixel),
        .o_valid     (o_valid),
        .o_sum       (o_sum),
        .o_center    (o_center),
        .o_row       (o_row),
        .o_col       (o_col),
        .o_bin       (o_bin)
    );

    result_checker u_checker (
        .clk             (clk),
        .rst             (rst),
        .i_pix_valid     (i_pix_valid),
        .i_sof           (i_sof),
        .i_pixel         (i_pixel),
        .i_valid         (o_valid),
        .i_sum           (o_sum),
        .i_center        (o_center),
        .i_row           (o_row),
        .i_col           (o_col),
        .i_bin           (o_bin),
        .i_test_end      (test_end),
        .i_test_idx      (test_idx),
        .i_exp_ones      (exp_ones),
        .o_frame_outputs (frame_outputs),
        .o_error_count   (error_count),
        .o_total_outputs (total_outputs)
    );

    // ##################################################
    // stimulus sources
    // ##################################################

    // galois form, x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic [15:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 16'hB400;
        end
        return n;
    endfunction

    task automatic take_bits(input int n, output logic [7:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            v    = {v[6:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic img_pkg::pixel_t pattern_pixel(input int kind, input img_pkg::pixel_t k,
                                                      input int r, input int c);
        img_pkg::pixel_t p;
        p = k;
        if (kind == KIND_RAMP) begin
            p = k + img_pkg::pixel_t'(8 * c);
        end else if (kind == KIND_CHECKER) begin
            p = ((r + c) % 2 == 0) ? k : ~k;
        end
        return p;
    endfunction

    task automatic add_test(input int i, input string name, input int kind,
                            input img_pkg::pixel_t k, input logic gaps, input int ones,
                            input int abort);
        t_name[i]  = name;
        t_kind[i]  = kind;
        t_const[i] = k;
        t_gaps[i]  = gaps;
        t_ones[i]  = ones;
        t_abort[i] = abort;
    endtask

    // ##################################################
    // frame driver
    // ##################################################

    task automatic idle_cycle();
        @(posedge clk);
        i_pix_valid <= 1'b0;
        i_sof       <= 1'b0;
    endtask

    task automatic drive_frame(input int t);
        logic [7:0]      bits;
        img_pkg::pixel_t p;
        int              n;
        int              r;
        int              c;
        // the full frame restarts the raster with its own first pixel.
        for (int i = 0; i < t_abort[t] + img_pkg::IMG_ROWS * img_pkg::IMG_COLS; i++) begin
            n = (i < t_abort[t]) ? i : i - t_abort[t];
            r = n / img_pkg::IMG_COLS;
            c = n % img_pkg::IMG_COLS;
            if (t_gaps[t]) begin
                take_bits(1, bits);
                if (bits[0]) begin
                    idle_cycle();
                end
            end
            if (t_kind[t] == KIND_RANDOM) begin
                take_bits(8, p);
            end else begin
                p = pattern_pixel(t_kind[t], t_const[t], r, c);
            end
            @(posedge clk);
            i_pix_valid <= 1'b1;
            i_sof       <= (n == 0);
            i_pixel     <= p;
        end
        idle_cycle();
    endtask

    task automatic wait_outputs(output logic ok);
        int cycles;
        cycles = 0;
        while (frame_outputs < OUT_PER_FRAME && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        ok = (frame_outputs >= OUT_PER_FRAME);
    endtask

    initial begin
        logic ok;
        int   failures;
        rst         = 1'b1;
        i_pix_valid = 1'b0;
        i_sof       = 1'b0;
        i_pixel     = '0;
        test_end    = 1'b0;
        test_idx    = 0;
        exp_ones    = -1;
        timeouts    = 0;
        tests_run   = 0;
        lfsr        = LFSR_SEED;
        add_test(0, "constant", KIND_CONST, 8'd100, 1'b0, 0, 0);
        add_test(1, "column ramp", KIND_RAMP, 8'd20, 1'b0, 0, 0);
        add_test(2, "checkerboard", KIND_CHECKER, 8'd200, 1'b0, 24, 0);
        add_test(3, "random", KIND_RANDOM, 8'd0, 1'b0, -1, 0);
        add_test(4, "random gaps", KIND_RANDOM, 8'd0, 1'b1, -1, 0);
        add_test(5, "random gaps restart", KIND_RANDOM, 8'd0, 1'b1, -1, ABORT_PIXELS);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            drive_frame(t);
            wait_outputs(ok);
            if (!ok) begin
                $display("timeout: test %0d (%0s) gave %0d of %0d results",
                         t, t_name[t], frame_outputs, OUT_PER_FRAME);
                timeouts++;
                break;
            end
            // a stray extra result would show up within the pipeline depth.
            for (int k = 0; k < DRAIN_CYCLES; k++) begin
                @(posedge clk);
            end
            test_end <= 1'b1;
            test_idx <= t;
            exp_ones <= t_ones[t];
            @(posedge clk);
            test_end <= 1'b0;
            tests_run++;
        end

        @(posedge clk);
        failures = error_count + timeouts + UUT.u_props.assert_fails;
        $display("tests %0d, results checked %0d, errors %0d, timeouts %0d",
                 tests_run, total_outputs, error_count + UUT.u_props.assert_fails, timeouts);
        if (failures == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/result_checker.sv
`timescale 1ns/1ns
`default_nettype none

module result_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_pix_valid,
    input  wire                     i_sof,
    input  wire img_pkg::pixel_t    i_pixel,
    input  wire                     i_valid,
    input  wire filt_pkg::win_sum_t i_sum,
    input  wire img_pkg::pixel_t    i_center,
    input  wire img_pkg::coord_t    i_row,
    input  wire img_pkg::coord_t    i_col,
    input  wire                     i_bin,
    input  wire                     i_test_end,
    input  int                      i_test_idx,
    input  int                      i_exp_ones,
    output int                      o_frame_outputs,
    output int                      o_error_count,
    output int                      o_total_outputs
);

    localparam int R         = filt_pkg::WIN_RADIUS;
    localparam int INNER_COLS = img_pkg::IMG_COLS - 2 * R;
    localparam int FRAME_OUTS = INNER_COLS * (img_pkg::IMG_ROWS - 2 * R);

    // last frame as driven, indexed by row and column.
    int image [img_pkg::IMG_ROWS][img_pkg::IMG_COLS];
    int in_row;
    int in_col;
    int frame_ones;
    int frame_errors;

    task automatic report_mismatch(input string what, input int got, input int want,
                                   input int r, input int c);
        $display("mismatch at %0t ns: %0s is %0d, expected %0d, centre (%0d,%0d)",
                 $time, what, got, want, r, c);
        o_error_count++;
        frame_errors++;
    endtask

    task automatic record_pixel();
        if (i_sof) begin
            in_row = 0;
            in_col = 0;
        end
        if (in_row < img_pkg::IMG_ROWS) begin
            image[in_row][in_col] = int'(i_pixel);
        end
        in_col++;
        if (in_col == img_pkg::IMG_COLS) begin
            in_col = 0;
            in_row++;
        end
    endtask

    // ##################################################
    // reference model
    // ##################################################

    task automatic check_output();
        int exp_row;
        int exp_col;
        int exp_sum;
        int exp_center;
        int exp_bin;
        if (o_frame_outputs >= FRAME_OUTS) begin
            $display("extra result at %0t ns: test %0d gave more than %0d results",
                     $time, i_test_idx, FRAME_OUTS);
            o_error_count++;
            frame_errors++;
        end else begin
            // interior centres come out in raster order.
            exp_row = R + o_frame_outputs / INNER_COLS;
            exp_col = R + o_frame_outputs % INNER_COLS;
            exp_sum = 0;
            for (int dr = -R; dr <= R; dr++) begin
                for (int dc = -R; dc <= R; dc++) begin
                    exp_sum += image[exp_row + dr][exp_col + dc];
                end
            end
            exp_center = image[exp_row][exp_col];
            exp_bin    = (exp_center * filt_pkg::WIN_AREA > exp_sum) ? 1 : 0;
            if (int'(i_row) != exp_row) begin
                report_mismatch("o_row", int'(i_row), exp_row, exp_row, exp_col);
            end
            if (int'(i_col) != exp_col) begin
                report_mismatch("o_col", int'(i_col), exp_col, exp_row, exp_col);
            end
            if (int'(i_sum) != exp_sum) begin
                report_mismatch("o_sum", int'(i_sum), exp_sum, exp_row, exp_col);
            end
            if (int'(i_center) != exp_center) begin
                report_mismatch("o_center", int'(i_center), exp_center, exp_row, exp_col);
            end
            if (int'(i_bin) != exp_bin) begin
                report_mismatch("o_bin", int'(i_bin), exp_bin, exp_row, exp_col);
            end
        end
        if (i_bin) begin
            frame_ones++;
        end
        o_frame_outputs++;
        o_total_outputs++;
    endtask

    task automatic end_test();
        if (o_frame_outputs != FRAME_OUTS) begin
            $display("test %0d ended with %0d results instead of %0d",
                     i_test_idx, o_frame_outputs, FRAME_OUTS);
            o_error_count++;
            frame_errors++;
        end
        if (i_exp_ones >= 0 && frame_ones != i_exp_ones) begin
            $display("mismatch at %0t ns: test %0d has %0d set o_bin bits, expected %0d",
                     $time, i_test_idx, frame_ones, i_exp_ones);
            o_error_count++;
            frame_errors++;
        end
        $display("test %0d done: %0d results, %0d with o_bin set, %0d errors",
                 i_test_idx, o_frame_outputs, frame_ones, frame_errors);
        o_frame_outputs = 0;
        frame_ones      = 0;
        frame_errors    = 0;
    endtask

    // sampled mid-cycle, away from the driving edge.
    always @(negedge clk) begin
        if (rst) begin
            in_row          = 0;
            in_col          = 0;
            frame_ones      = 0;
            frame_errors    = 0;
            o_frame_outputs = 0;
            o_error_count   = 0;
            o_total_outputs = 0;
        end else begin
            if (i_pix_valid) begin
                record_pixel();
            end
            if (i_valid) begin
                check_output();
            end
            if (i_test_end) begin
                end_test();
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/box_thresh_properties.sv
`timescale 1ns/1ns
`default_nettype none

module box_thresh_properties (
    input wire                     clk,
    input wire                     rst,
    input wire                     i_valid,
    input wire filt_pkg::win_sum_t i_sum,
    input wire img_pkg::coord_t    i_row,
    input wire img_pkg::coord_t    i_col
);

    localparam int LO      = filt_pkg::WIN_RADIUS;
    localparam int ROW_HI  = img_pkg::IMG_ROWS - 1 - filt_pkg::WIN_RADIUS;
    localparam int COL_HI  = img_pkg::IMG_COLS - 1 - filt_pkg::WIN_RADIUS;
    localparam int MAX_SUM = filt_pkg::WIN_AREA * 255;

    int assert_fails = 0;

    // no result leaves the pipeline while reset is applied.
    valid_low_in_reset: assert property (@(posedge clk) rst |=> !i_valid)
        else begin
            assert_fails++;
            $error("o_valid high during reset");
        end

    interior_position: assert property (@(posedge clk) disable iff (rst)
        i_valid |-> (int'(i_row) >= LO && int'(i_row) <= ROW_HI
                  && int'(i_col) >= LO && int'(i_col) <= COL_HI))
        else begin
            assert_fails++;
            $error("centre position outside the interior");
        end

    sum_in_range: assert property (@(posedge clk) disable iff (rst)
        i_valid |-> int'(i_sum) <= MAX_SUM)
        else begin
            assert_fails++;
            $error("window sum above 25 full-scale pixels");
        end

endmodule

bind box_thresh_top box_thresh_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .i_valid (o_valid),
    .i_sum   (o_sum),
    .i_row   (o_row),
    .i_col   (o_col)
);

`default_nettype wire

//--- design/box_thresh_top.sv
`timescale 1ns/1ns
`default_nettype none

module box_thresh_top (
    input  wire                  clk,
    input  wire                  rst,
    // pixel stream in raster order.
    input  wire                  i_pix_valid,
    input  wire                  i_sof,
    input  wire img_pkg::pixel_t i_pixel,
    // one result per interior pixel.
    output logic                 o_valid,
    output filt_pkg::win_sum_t   o_sum,
    output img_pkg::pixel_t      o_center,
    output img_pkg::coord_t      o_row,
    output img_pkg::coord_t      o_col,
    output logic                 o_bin
);

    // ##################################################
    // internal buses
    // ##################################################

    pixel_column_if col_bus ();
    window_if       win_bus ();

    // ##################################################
    // pipeline
    // ##################################################

    // four row memories, one column per pixel.
    line_buffer u_line_buffer (
        .clk         (clk),
        .rst         (rst),
        .i_pix_valid (i_pix_valid),
        .i_sof       (i_sof),
        .i_pixel     (i_pixel),
        .col_o       (col_bus.source)
    );

    // column sums and running 5x5 sum.
    window_sum u_window_sum (
        .clk   (clk),
        .rst   (rst),
        .col_i (col_bus.sink),
        .win_o (win_bus.source)
    );

    // binary decision.
    threshold_out u_threshold_out (
        .clk      (clk),
        .rst      (rst),
        .win_i    (win_bus.sink),
        .o_valid  (o_valid),
        .o_sum    (o_sum),
        .o_center (o_center),
        .o_row    (o_row),
        .o_col    (o_col),
        .o_bin    (o_bin)
    );

endmodule

`default_nettype wire

//--- design/threshold_out.sv
`timescale 1ns/1ns
`default_nettype none

module threshold_out (
    input  wire                 clk,
    input  wire                 rst,
    window_if.sink              win_i,
    output logic                o_valid,
    output filt_pkg::win_sum_t  o_sum,
    output img_pkg::pixel_t     o_center,
    output img_pkg::coord_t     o_row,
    output img_pkg::coord_t     o_col,
    output logic                o_bin
);

    // centre scaled to the window area, so no division is needed.
    filt_pkg::win_sum_t center_scaled;

    assign center_scaled = filt_pkg::win_sum_t'(win_i.center)
                         * filt_pkg::win_sum_t'(filt_pkg::WIN_AREA);

    // ##################################################
    // output registers
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= win_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (win_i.valid) begin
            o_sum    <= win_i.sum;
            o_center <= win_i.center;
            // move from the newest pixel back to the window centre.
            o_row    <= win_i.row - img_pkg::coord_t'(filt_pkg::WIN_RADIUS);
            o_col    <= win_i.col - img_pkg::coord_t'(filt_pkg::WIN_RADIUS);
            o_bin    <= (center_scaled > win_i.sum);
        end
    end

endmodule

`default_nettype wire

//--- design/window_sum.sv
`timescale 1ns/1ns
`default_nettype none

module window_sum (
    input  wire           clk,
    input  wire           rst,
    pixel_column_if.sink  col_i,
    window_if.source      win_o
);

    // stage 1 registers.
    logic               s1_valid;
    filt_pkg::col_sum_t s1_pair_a;
    filt_pkg::col_sum_t s1_pair_b;
    img_pkg::pixel_t    s1_last;
    img_pkg::pixel_t    s1_mid;
    img_pkg::coord_t    s1_row;
    img_pkg::coord_t    s1_col;

    // stage 2 and running sum.
    filt_pkg::col_sum_t col_sum;
    filt_pkg::col_sum_t col_hist [filt_pkg::WIN_SIZE];
    img_pkg::pixel_t    mid_hist [filt_pkg::WIN_RADIUS+1];
    filt_pkg::win_sum_t acc;
    logic               first_col;
    logic               full_win;

    // ##################################################
    // column adder tree, pair stage
    // ##################################################

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= col_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (col_i.valid) begin
            s1_pair_a <= filt_pkg::col_sum_t'(col_i.pix[0])
                       + filt_pkg::col_sum_t'(col_i.pix[1]);
            s1_pair_b <= filt_pkg::col_sum_t'(col_i.pix[2])
                       + filt_pkg::col_sum_t'(col_i.pix[3]);
            s1_last   <= col_i.pix[4];
            // the middle row is the centre row of the window.
            s1_mid    <= col_i.pix[filt_pkg::WIN_RADIUS];
            s1_row    <= col_i.row;
            s1_col    <= col_i.col;
        end
    end

    // ##################################################
    // final column sum and running row sum
    // ##################################################

    // all five pixels, folded into the accumulator register below.
    assign col_sum   = s1_pair_a + s1_pair_b + filt_pkg::col_sum_t'(s1_last);
    assign first_col = (s1_col == '0);
    assign full_win  = (s1_col >= img_pkg::coord_t'(filt_pkg::WIN_SIZE - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            win_o.valid <= 1'b0;
        end else begin
            win_o.valid <= s1_valid && full_win;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            col_hist[0] <= col_sum;
            for (int k = 1; k < filt_pkg::WIN_SIZE; k++) begin
                col_hist[k] <= first_col ? '0 : col_hist[k-1];
            end

            // add the newest column, drop the one five back.
            if (first_col) begin
                acc <= filt_pkg::win_sum_t'(col_sum);
            end else begin
                acc <= acc + filt_pkg::win_sum_t'(col_sum)
                     - filt_pkg::win_sum_t'(col_hist[filt_pkg::WIN_SIZE-1]);
            end
        end
    end

    // ##################################################
    // centre pixel and coordinates
    // ##################################################

    // centre sits two columns behind the newest column.
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            mid_hist[0] <= s1_mid;
            for (int k = 1; k <= filt_pkg::WIN_RADIUS; k++) begin
                mid_hist[k] <= mid_hist[k-1];
            end
            win_o.row <= s1_row;
            win_o.col <= s1_col;
        end
    end

    assign win_o.sum    = acc;
    assign win_o.center = mid_hist[filt_pkg::WIN_RADIUS];

endmodule

`default_nettype wire

//--- design/line_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module line_buffer (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  i_pix_valid,
    input  wire                  i_sof,
    input  wire img_pkg::pixel_t i_pixel,
    pixel_column_if.source       col_o
);

    // row_mem[0] holds the oldest stored row.
    img_pkg::pixel_t row_mem [filt_pkg::WIN_SIZE-1][img_pkg::IMG_COLS];

    filt_pkg::lb_state_t state;

    img_pkg::coord_t col_cnt;
    img_pkg::coord_t row_cnt;
    img_pkg::coord_t cur_col;
    img_pkg::coord_t cur_row;
    img_pkg::coord_t next_row;

    logic [img_pkg::COL_ADDR_W-1:0] addr;
    logic                           last_col;
    logic                           last_row;
    logic                           emit;

    // ##################################################
    // raster position
    // ##################################################

    // a first pixel restarts the raster at the origin.
    assign cur_col  = i_sof ? '0 : col_cnt;
    assign cur_row  = i_sof ? '0 : row_cnt;
    assign next_row = cur_row + 1'b1;
    assign addr     = cur_col[img_pkg::COL_ADDR_W-1:0];
    assign last_col = (cur_col == img_pkg::coord_t'(img_pkg::IMG_COLS - 1));
    assign last_row = (cur_row == img_pkg::coord_t'(img_pkg::IMG_ROWS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt <= '0;
            row_cnt <= '0;
            state   <= filt_pkg::FILL;
        end else if (i_pix_valid) begin
            if (last_col) begin
                col_cnt <= '0;
                if (last_row) begin
                    row_cnt <= '0;
                    state   <= filt_pkg::FILL;
                end else begin
                    row_cnt <= next_row;
                    // four rows stored, the window can be formed.
                    if (next_row == img_pkg::coord_t'(filt_pkg::WIN_SIZE - 1)) begin
                        state <= filt_pkg::STREAM;
                    end
                end
            end else begin
                col_cnt <= cur_col + 1'b1;
                row_cnt <= cur_row;
                if (i_sof) begin
                    state <= filt_pkg::FILL;
                end
            end
        end
    end

    // ##################################################
    // row memories
    // ##################################################

    // each column slot shifts up one row per incoming pixel.
    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            for (int k = 0; k < filt_pkg::WIN_SIZE - 2; k++) begin
                row_mem[k][addr] <= row_mem[k+1][addr];
            end
            row_mem[filt_pkg::WIN_SIZE-2][addr] <= i_pixel;
        end
    end

    // ##################################################
    // column output
    // ##################################################

    assign emit = i_pix_valid && !i_sof && (state == filt_pkg::STREAM);

    always_ff @(posedge clk) begin
        if (rst) begin
            col_o.valid <= 1'b0;
        end else begin
            col_o.valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (i_pix_valid) begin
            for (int k = 0; k < filt_pkg::WIN_SIZE - 1; k++) begin
                col_o.pix[k] <= row_mem[k][addr];
            end
            col_o.pix[filt_pkg::WIN_SIZE-1] <= i_pixel;
            col_o.row <= cur_row;
            col_o.col <= cur_col;
        end
    end

endmodule

`default_nettype wire

//--- design/window_if.sv
`timescale 1ns/1ns
`default_nettype none

interface window_if;

    logic               valid;
    filt_pkg::win_sum_t sum;
    img_pkg::pixel_t    center;
    // coordinates of the newest pixel in the window.
    img_pkg::coord_t    row;
    img_pkg::coord_t    col;

    modport source (output valid, output sum, output center, output row, output col);
    modport sink   (input valid, input sum, input center, input row, input col);

endinterface

`default_nettype wire

//--- design/pixel_column_if.sv
`timescale 1ns/1ns
`default_nettype none

interface pixel_column_if;

    logic            valid;
    // index 0 is the oldest row, index 4 the incoming pixel.
    img_pkg::pixel_t pix [5];
    // position of the newest pixel.
    img_pkg::coord_t row;
    img_pkg::coord_t col;

    modport source (output valid, output pix, output row, output col);
    modport sink   (input valid, input pix, input row, input col);

endinterface

`default_nettype wire

//--- design/filt_pkg.sv
`default_nettype none

package filt_pkg;

    // window geometry.
    localparam int WIN_RADIUS = 2;
    localparam int WIN_SIZE   = 2 * WIN_RADIUS + 1;
    localparam int WIN_AREA   = WIN_SIZE * WIN_SIZE;

    // sum of five pixels, then of twenty-five.
    typedef logic [10:0] col_sum_t;
    typedef logic [12:0] win_sum_t;

    typedef enum logic {
        FILL,
        STREAM
    } lb_state_t;

endpackage

`default_nettype wire

//--- design/img_pkg.sv
`default_nettype none

package img_pkg;

    // frame geometry of this build.
    localparam int IMG_COLS = 16;
    localparam int IMG_ROWS = 8;

    // address width of one row memory.
    localparam int COL_ADDR_W = $clog2(IMG_COLS);

    // 8-bit greyscale sample.
    typedef logic [7:0] pixel_t;

    // row or column index, wide enough for both dimensions.
    typedef logic [4:0] coord_t;

endpackage

`default_nettype wire
